/* source/id_pkg.sv */
package id_pkg;

   //////////////////////////////////////////////////
   // Widths and vector types
   //////////////////////////////////////////////////

   localparam int NB_WORD     = 32;
   localparam int NB_REG_ADDR = 5;

   typedef logic [NB_WORD-1:0]     word_t;
   typedef logic [NB_REG_ADDR-1:0] reg_addr_t;
   typedef logic [15:0]            imm_t;
   typedef logic [4:0]             shamt_t;
   typedef logic [25:0]            jtarget_t;
   typedef logic [5:0]             opcode_t;
   typedef logic [5:0]             funct_t;
   typedef logic [3:0]             alu_op_t;
   typedef logic [1:0]             dsize_t;

   localparam dsize_t SIZE_BYTE = 2'd0;
   localparam dsize_t SIZE_HALF = 2'd1;
   localparam dsize_t SIZE_WORD = 2'd2;

   // Link register for JAL
   localparam reg_addr_t RA_ADDR = 5'd31;

   //////////////////////////////////////////////////
   // Opcodes and function codes
   //////////////////////////////////////////////////

   localparam opcode_t OP_RTYPE = 6'b000000;
   localparam opcode_t OP_LB    = 6'b100000;
   localparam opcode_t OP_LH    = 6'b100001;
   localparam opcode_t OP_LW    = 6'b100011;
   localparam opcode_t OP_LBU   = 6'b100100;
   localparam opcode_t OP_LHU   = 6'b100101;
   localparam opcode_t OP_LWU   = 6'b100111;
   localparam opcode_t OP_SB    = 6'b101000;
   localparam opcode_t OP_SH    = 6'b101001;
   localparam opcode_t OP_SW    = 6'b101011;
   localparam opcode_t OP_ADDI  = 6'b001001;
   localparam opcode_t OP_ANDI  = 6'b001100;
   localparam opcode_t OP_ORI   = 6'b001101;
   localparam opcode_t OP_XORI  = 6'b001110;
   localparam opcode_t OP_LUI   = 6'b001111;
   localparam opcode_t OP_SLTI  = 6'b001010;
   localparam opcode_t OP_BEQ   = 6'b000100;
   localparam opcode_t OP_BNE   = 6'b000101;
   localparam opcode_t OP_J     = 6'b000010;
   localparam opcode_t OP_JAL   = 6'b000011;
   localparam opcode_t OP_HLT   = 6'b111111;

   localparam funct_t FN_SLL  = 6'b000000;
   localparam funct_t FN_SRL  = 6'b000010;
   localparam funct_t FN_SRA  = 6'b000011;
   localparam funct_t FN_SLLV = 6'b000100;
   localparam funct_t FN_SRLV = 6'b000110;
   localparam funct_t FN_SRAV = 6'b000111;
   localparam funct_t FN_ADDU = 6'b100001;
   localparam funct_t FN_SUBU = 6'b100011;
   localparam funct_t FN_AND  = 6'b100100;
   localparam funct_t FN_OR   = 6'b100101;
   localparam funct_t FN_XOR  = 6'b100110;
   localparam funct_t FN_NOR  = 6'b100111;
   localparam funct_t FN_SLT  = 6'b101010;
   localparam funct_t FN_JR   = 6'b001000;
   localparam funct_t FN_JALR = 6'b001001;

   // Codes understood by the EX stage ALU
   localparam alu_op_t ALU_ADD = 4'd0;
   localparam alu_op_t ALU_SUB = 4'd1;
   localparam alu_op_t ALU_AND = 4'd2;
   localparam alu_op_t ALU_OR  = 4'd3;
   localparam alu_op_t ALU_XOR = 4'd4;
   localparam alu_op_t ALU_NOR = 4'd5;
   localparam alu_op_t ALU_SRL = 4'd6;
   localparam alu_op_t ALU_SLL = 4'd7;
   localparam alu_op_t ALU_SRA = 4'd8;
   localparam alu_op_t ALU_SLT = 4'd10;
   localparam alu_op_t ALU_LUI = 4'd11;

   //////////////////////////////////////////////////
   // Control frames
   //////////////////////////////////////////////////

   typedef struct packed {
      alu_op_t alu_op;
      logic    use_imm;
      logic    imm_unsigned;
      logic    use_shamt;
   } ex_ctrl_t;

   typedef struct packed {
      logic   rd_en;
      logic   wr_en;
      logic   load_unsigned;
      dsize_t size;
   } mem_ctrl_t;

   typedef struct packed {
      reg_addr_t dest;
      logic      reg_we;
      logic      from_alu;
      logic      link_pc;
   } wb_ctrl_t;

   // Stays inside the decode stage
   typedef struct packed {
      logic is_branch;
      logic branch_ne;
      logic jump_reg;
      logic jump_imm;
   } flow_ctrl_t;

endpackage

/* source/control_decoder.sv */
module control_decoder
   import id_pkg::*;
(
   input  word_t      i_instruction,
   input  logic       i_valid,
   output ex_ctrl_t   o_ex,
   output mem_ctrl_t  o_mem,
   output wb_ctrl_t   o_wb,
   output flow_ctrl_t o_flow,
   output logic       o_advance
);

   opcode_t   opcode;
   funct_t    funct;
   reg_addr_t rt;
   reg_addr_t rd;
   logic      to_ra;
   logic      known;

   assign opcode = i_instruction[31:26];
   assign rt     = i_instruction[20:16];
   assign rd     = i_instruction[15:11];
   assign funct  = i_instruction[5:0];

   // HLT parks the stage until a new instruction shows up
   assign o_advance = i_valid && (opcode != OP_HLT);

   // Low opcode bits give the access width for loads and stores
   function automatic dsize_t size_of(input opcode_t op);
      case (op[1:0])
         2'b00:   return SIZE_BYTE;
         2'b01:   return SIZE_HALF;
         default: return SIZE_WORD;
      endcase
   endfunction

   function automatic alu_op_t imm_alu(input opcode_t op);
      case (op)
         OP_ANDI: return ALU_AND;
         OP_ORI:  return ALU_OR;
         OP_XORI: return ALU_XOR;
         OP_LUI:  return ALU_LUI;
         OP_SLTI: return ALU_SLT;
         default: return ALU_ADD;
      endcase
   endfunction

   always_comb begin
      o_ex   = '0;
      o_mem  = '0;
      o_wb   = '0;
      o_flow = '0;
      to_ra  = 1'b0;
      known  = 1'b1;

      case (opcode)
         OP_RTYPE: begin
            o_wb.reg_we   = 1'b1;
            o_wb.from_alu = 1'b1;
            case (funct)
               FN_SLL: begin
                  o_ex.alu_op    = ALU_SLL;
                  o_ex.use_shamt = 1'b1;
               end
               FN_SRL: begin
                  o_ex.alu_op    = ALU_SRL;
                  o_ex.use_shamt = 1'b1;
               end
               FN_SRA: begin
                  o_ex.alu_op    = ALU_SRA;
                  o_ex.use_shamt = 1'b1;
               end
               FN_SLLV: o_ex.alu_op = ALU_SLL;
               FN_SRLV: o_ex.alu_op = ALU_SRL;
               FN_SRAV: o_ex.alu_op = ALU_SRA;
               FN_ADDU: o_ex.alu_op = ALU_ADD;
               FN_SUBU: o_ex.alu_op = ALU_SUB;
               FN_AND:  o_ex.alu_op = ALU_AND;
               FN_OR:   o_ex.alu_op = ALU_OR;
               FN_XOR:  o_ex.alu_op = ALU_XOR;
               FN_NOR:  o_ex.alu_op = ALU_NOR;
               FN_SLT:  o_ex.alu_op = ALU_SLT;
               FN_JR:   o_flow.jump_reg = 1'b1;
               FN_JALR: begin
                  o_flow.jump_reg = 1'b1;
                  o_wb.link_pc    = 1'b1;
               end
               default: o_ex.alu_op = ALU_ADD;
            endcase
         end
         OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_LWU: begin
            o_ex.use_imm        = 1'b1;
            o_mem.rd_en         = 1'b1;
            o_mem.load_unsigned = opcode inside {OP_LBU, OP_LHU, OP_LWU};
            o_mem.size          = size_of(opcode);
            o_wb.reg_we         = 1'b1;
         end
         OP_SB, OP_SH, OP_SW: begin
            o_ex.use_imm = 1'b1;
            o_mem.wr_en  = 1'b1;
            o_mem.size   = size_of(opcode);
         end
         OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
            o_ex.alu_op       = imm_alu(opcode);
            o_ex.use_imm      = 1'b1;
            o_ex.imm_unsigned = !(opcode inside {OP_ADDI, OP_SLTI});
            o_wb.reg_we       = 1'b1;
            o_wb.from_alu     = 1'b1;
         end
         OP_BEQ, OP_BNE: begin
            o_ex.use_imm     = 1'b1;
            o_flow.is_branch = 1'b1;
            o_flow.branch_ne = (opcode == OP_BNE);
         end
         OP_J: o_flow.jump_imm = 1'b1;
         OP_JAL: begin
            o_flow.jump_imm = 1'b1;
            to_ra           = 1'b1;
            o_wb.reg_we     = 1'b1;
            o_wb.link_pc    = 1'b1;
         end
         default: known = 1'b0;
      endcase

      // Destination register, writes to r0 dropped
      if (known) begin
         if (to_ra) begin
            o_wb.dest = RA_ADDR;
         end else if (o_ex.use_imm) begin
            o_wb.dest = rt;
         end else begin
            o_wb.dest = rd;
         end
         o_wb.reg_we = o_wb.reg_we && (o_wb.dest != '0);
      end
   end

   // No opcode may both load and store
   always_comb begin
      assert (!(o_mem.rd_en && o_mem.wr_en))
         else $error("control_decoder: load and store decoded together");
   end

endmodule

/* source/register_file.sv */
module register_file
   import id_pkg::*;
#(
   parameter int NB_DATA = NB_WORD,
   parameter int NB_REGS = 32
)(
   input  logic               i_clk,
   input  logic               i_rst,
   input  logic               i_we,
   input  reg_addr_t          i_waddr,
   input  logic [NB_DATA-1:0] i_wdata,
   input  reg_addr_t          i_raddr_a,
   input  reg_addr_t          i_raddr_b,
   output logic [NB_DATA-1:0] o_rdata_a,
   output logic [NB_DATA-1:0] o_rdata_b
);

   logic [NB_DATA-1:0] regs [NB_REGS];

   // Asynchronous reads
   assign o_rdata_a = regs[i_raddr_a];
   assign o_rdata_b = regs[i_raddr_b];

   // Written mid-cycle so the same cycle's decode sees the new value
   always_ff @(negedge i_clk) begin
      if (i_rst) begin
         for (int i = 0; i < NB_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (i_we) begin
         regs[i_waddr] <= i_wdata;
      end
   end

   // Writes stay inside the implemented registers
   property p_waddr_range;
      @(negedge i_clk) disable iff (i_rst) i_we |-> (int'(i_waddr) < NB_REGS);
   endproperty
   assert property (p_waddr_range)
      else $error("register_file: write to missing register %0d", i_waddr);

endmodule

/* source/branch_resolver.sv */
module branch_resolver
   import id_pkg::*;
#(
   parameter int NB_DATA = NB_WORD
)(
   input  logic               i_clk,
   input  logic               i_rst,
   input  logic               i_advance,
   input  flow_ctrl_t         i_flow,
   input  logic [NB_DATA-1:0] i_rs_data,
   input  logic [NB_DATA-1:0] i_rt_data,
   output logic               o_branch,
   output logic               o_branch_result,
   output logic               o_jump_rs,
   output logic               o_jump_inm,
   output logic               o_nop
);

   logic equal;
   logic taken;

   assign equal = (i_rs_data == i_rt_data);
   // BNE flips the sense of the compare
   assign taken = i_flow.is_branch && (equal ^ i_flow.branch_ne);

   assign o_branch        = i_flow.is_branch;
   assign o_branch_result = taken;
   assign o_jump_rs       = i_flow.jump_reg;
   assign o_jump_inm      = i_flow.jump_imm;

   // Squash the slot behind any redirect
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_nop <= 1'b0;
      end else if (i_advance) begin
         o_nop <= taken || i_flow.jump_reg || i_flow.jump_imm;
      end
   end

   // One redirect source per instruction from the decoder
   assert property (@(posedge i_clk) disable iff (i_rst)
                    $onehot0({i_flow.is_branch, i_flow.jump_reg, i_flow.jump_imm}))
      else $error("branch_resolver: more than one redirect requested");

endmodule

/* source/id_ex_register.sv */
module id_ex_register
   import id_pkg::*;
#(
   parameter int NB_DATA = NB_WORD
)(
   input  logic               i_clk,
   input  logic               i_rst,
   input  logic               i_advance,
   input  ex_ctrl_t           i_ex,
   input  mem_ctrl_t          i_mem,
   input  wb_ctrl_t           i_wb,
   input  logic [NB_DATA-1:0] i_a,
   input  logic [NB_DATA-1:0] i_b,
   input  imm_t               i_imm,
   input  shamt_t             i_shamt,
   input  word_t              i_pc,
   output ex_ctrl_t           o_ex,
   output mem_ctrl_t          o_mem,
   output wb_ctrl_t           o_wb,
   output logic [NB_DATA-1:0] o_a,
   output logic [NB_DATA-1:0] o_b,
   output imm_t               o_imm,
   output shamt_t             o_shamt,
   output word_t              o_pc
);

   //////////////////////////////////////////////////
   // ID/EX boundary
   //////////////////////////////////////////////////

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_ex    <= '0;
         o_mem   <= '0;
         o_wb    <= '0;
         o_a     <= '0;
         o_b     <= '0;
         o_imm   <= '0;
         o_shamt <= '0;
         o_pc    <= '0;
      end else if (i_advance) begin
         o_ex    <= i_ex;
         o_mem   <= i_mem;
         o_wb    <= i_wb;
         o_a     <= i_a;
         o_b     <= i_b;
         o_imm   <= i_imm;
         o_shamt <= i_shamt;
         o_pc    <= i_pc;
      end
   end

   // A store handed to EX never writes back a register
   assert property (@(posedge i_clk) disable iff (i_rst) o_mem.wr_en |-> !o_wb.reg_we)
      else $error("id_ex_register: store frame with register write");

   // Loads return memory data, not the ALU result
   assert property (@(posedge i_clk) disable iff (i_rst) o_mem.rd_en |-> !o_wb.from_alu)
      else $error("id_ex_register: load frame selects ALU result");

endmodule

/* source/instruction_decode.sv */
module instruction_decode
   import id_pkg::*;
#(
   parameter int NB_DATA = NB_WORD,
   parameter int NB_REGS = 32
)(
   input  logic               i_clk,
   input  logic               i_rst,
   input  logic               i_valid,
   input  word_t              i_instruction,
   input  word_t              i_pc,
   input  logic               i_regfile_we,
   input  reg_addr_t          i_regfile_addr,
   input  logic [NB_DATA-1:0] i_regfile_data,
   output logic               o_advance,
   output ex_ctrl_t           o_ex_ctrl,
   output mem_ctrl_t          o_mem_ctrl,
   output wb_ctrl_t           o_wb_ctrl,
   output logic [NB_DATA-1:0] o_a,
   output logic [NB_DATA-1:0] o_b,
   output imm_t               o_imm,
   output shamt_t             o_shamt,
   output word_t              o_pc,
   output logic               o_nop,
   output logic               o_branch,
   output logic               o_branch_result,
   output logic               o_jump_rs,
   output logic [NB_DATA-1:0] o_jump_rs_addr,
   output logic               o_jump_inm,
   output jtarget_t           o_jump_inm_addr
);

   ex_ctrl_t           ex;
   mem_ctrl_t          mem;
   wb_ctrl_t           wb;
   flow_ctrl_t         flow;
   logic               advance;
   reg_addr_t          rs;
   reg_addr_t          rt;
   logic [NB_DATA-1:0] rs_data;
   logic [NB_DATA-1:0] rt_data;

   assign rs              = i_instruction[25:21];
   assign rt              = i_instruction[20:16];
   assign o_advance       = advance;
   assign o_jump_rs_addr  = rs_data;
   assign o_jump_inm_addr = i_instruction[25:0];

   control_decoder u_control_decoder (
      .i_instruction (i_instruction),
      .i_valid       (i_valid),
      .o_ex          (ex),
      .o_mem         (mem),
      .o_wb          (wb),
      .o_flow        (flow),
      .o_advance     (advance)
   );

   // Write-back is frozen along with the stage
   register_file #(.NB_DATA(NB_DATA), .NB_REGS(NB_REGS)) u_register_file (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_we      (i_regfile_we && advance),
      .i_waddr   (i_regfile_addr),
      .i_wdata   (i_regfile_data),
      .i_raddr_a (rs),
      .i_raddr_b (rt),
      .o_rdata_a (rs_data),
      .o_rdata_b (rt_data)
   );

   branch_resolver #(.NB_DATA(NB_DATA)) u_branch_resolver (
      .i_clk           (i_clk),
      .i_rst           (i_rst),
      .i_advance       (advance),
      .i_flow          (flow),
      .i_rs_data       (rs_data),
      .i_rt_data       (rt_data),
      .o_branch        (o_branch),
      .o_branch_result (o_branch_result),
      .o_jump_rs       (o_jump_rs),
      .o_jump_inm      (o_jump_inm),
      .o_nop           (o_nop)
   );

   id_ex_register #(.NB_DATA(NB_DATA)) u_id_ex_register (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_advance (advance),
      .i_ex      (ex),
      .i_mem     (mem),
      .i_wb      (wb),
      .i_a       (rs_data),
      .i_b       (rt_data),
      .i_imm     (i_instruction[15:0]),
      .i_shamt   (i_instruction[10:6]),
      .i_pc      (i_pc),
      .o_ex      (o_ex_ctrl),
      .o_mem     (o_mem_ctrl),
      .o_wb      (o_wb_ctrl),
      .o_a       (o_a),
      .o_b       (o_b),
      .o_imm     (o_imm),
      .o_shamt   (o_shamt),
      .o_pc      (o_pc)
   );

endmodule

/* test/tb_instruction_decode.sv */
module tb_instruction_decode
   import id_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   logic       i_clk;
   logic       i_rst;
   logic       i_valid;
   word_t      i_instruction;
   word_t      i_pc;
   logic       i_regfile_we;
   reg_addr_t  i_regfile_addr;
   word_t      i_regfile_data;
   logic       o_advance;
   ex_ctrl_t   o_ex_ctrl;
   mem_ctrl_t  o_mem_ctrl;
   wb_ctrl_t   o_wb_ctrl;
   word_t      o_a;
   word_t      o_b;
   imm_t       o_imm;
   shamt_t     o_shamt;
   word_t      o_pc;
   logic       o_nop;
   logic       o_branch;
   logic       o_branch_result;
   logic       o_jump_rs;
   word_t      o_jump_rs_addr;
   logic       o_jump_inm;
   jtarget_t   o_jump_inm_addr;

   integer      seed;
   logic [31:0] val_a;
   logic [31:0] val_b;
   logic [31:0] s_ex;
   logic [31:0] s_mem;
   logic [31:0] s_wb;
   logic [31:0] s_a;
   logic [31:0] s_b;
   logic [31:0] s_imm;
   logic [31:0] s_shamt;
   logic [31:0] s_pc;
   logic [31:0] s_nop;

   instruction_decode #(.NB_DATA(32), .NB_REGS(32)) dut_i (
      .i_clk           (i_clk),
      .i_rst           (i_rst),
      .i_valid         (i_valid),
      .i_instruction   (i_instruction),
      .i_pc            (i_pc),
      .i_regfile_we    (i_regfile_we),
      .i_regfile_addr  (i_regfile_addr),
      .i_regfile_data  (i_regfile_data),
      .o_advance       (o_advance),
      .o_ex_ctrl       (o_ex_ctrl),
      .o_mem_ctrl      (o_mem_ctrl),
      .o_wb_ctrl       (o_wb_ctrl),
      .o_a             (o_a),
      .o_b             (o_b),
      .o_imm           (o_imm),
      .o_shamt         (o_shamt),
      .o_pc            (o_pc),
      .o_nop           (o_nop),
      .o_branch        (o_branch),
      .o_branch_result (o_branch_result),
      .o_jump_rs       (o_jump_rs),
      .o_jump_rs_addr  (o_jump_rs_addr),
      .o_jump_inm      (o_jump_inm),
      .o_jump_inm_addr (o_jump_inm_addr)
   );

   initial begin
      i_clk = 1'b0;
      forever #4 i_clk = ~i_clk;
   end

   //////////////////////////////////////////////////
   // Encoders and expected frames
   //////////////////////////////////////////////////

   function automatic word_t rtype(reg_addr_t rs, reg_addr_t rt, reg_addr_t rd,
                                   shamt_t sh, funct_t fn);
      return {OP_RTYPE, rs, rt, rd, sh, fn};
   endfunction

   function automatic word_t itype(opcode_t op, reg_addr_t rs, reg_addr_t rt, imm_t imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic word_t jtype(opcode_t op, jtarget_t target);
      return {op, target};
   endfunction

   // Field order is alu_op, use_imm, imm_unsigned, use_shamt
   function automatic logic [31:0] ex_frame(alu_op_t alu, logic imm, logic uns, logic sh);
      return {25'b0, alu, imm, uns, sh};
   endfunction

   function automatic logic [31:0] mem_frame(logic rd, logic wr, logic uns, dsize_t size);
      return {27'b0, rd, wr, uns, size};
   endfunction

   function automatic logic [31:0] wb_frame(reg_addr_t dest, logic we, logic alu, logic link);
      return {24'b0, dest, we, alu, link};
   endfunction

   //////////////////////////////////////////////////
   // Drive and check
   //////////////////////////////////////////////////

   task automatic check_eq(string name, logic [31:0] exp, logic [31:0] act);
      if (exp !== act) begin
         $display("ERROR: %s expected %h actual %h", name, exp, act);
         $display("Simulation failed");
         $fatal(1);
      end
   endtask

   task automatic step();
      @(posedge i_clk);
      #1;
   endtask

   task automatic wait_advance();
      int cycles;
      cycles = 0;
      #1;
      while (!o_advance) begin
         if (cycles >= 20) begin
            $display("Timeout: the stage never accepted the instruction");
            $display("Simulation failed");
            $fatal(1);
         end
         @(posedge i_clk);
         #2;
         cycles++;
      end
   endtask

   task automatic present(word_t instr, word_t pc);
      i_valid       = 1'b1;
      i_instruction = instr;
      i_pc          = pc;
      wait_advance();
   endtask

   // Lands on the falling edge of the cycle
   task automatic write_reg(reg_addr_t addr, word_t data);
      i_regfile_we   = 1'b1;
      i_regfile_addr = addr;
      i_regfile_data = data;
      present(32'h0, 32'h0);
      step();
      i_regfile_we = 1'b0;
   endtask

   task automatic save_outputs();
      s_ex    = 32'(o_ex_ctrl);
      s_mem   = 32'(o_mem_ctrl);
      s_wb    = 32'(o_wb_ctrl);
      s_a     = o_a;
      s_b     = o_b;
      s_imm   = 32'(o_imm);
      s_shamt = 32'(o_shamt);
      s_pc    = o_pc;
      s_nop   = 32'(o_nop);
   endtask

   task automatic check_held(string name);
      check_eq(name, s_ex, 32'(o_ex_ctrl));
      check_eq(name, s_mem, 32'(o_mem_ctrl));
      check_eq(name, s_wb, 32'(o_wb_ctrl));
      check_eq(name, s_a, o_a);
      check_eq(name, s_b, o_b);
      check_eq(name, s_imm, 32'(o_imm));
      check_eq(name, s_shamt, 32'(o_shamt));
      check_eq(name, s_pc, o_pc);
      check_eq(name, s_nop, 32'(o_nop));
   endtask

   //////////////////////////////////////////////////
   // Directed tests
   //////////////////////////////////////////////////

   task automatic reset_values();
      check_eq("reset ex", 32'h0, 32'(o_ex_ctrl));
      check_eq("reset mem", 32'h0, 32'(o_mem_ctrl));
      check_eq("reset wb", 32'h0, 32'(o_wb_ctrl));
      check_eq("reset a", 32'h0, o_a);
      check_eq("reset b", 32'h0, o_b);
      check_eq("reset nop", 32'h0, 32'(o_nop));
   endtask

   task automatic rtype_ops();
      val_a = $random(seed);
      val_b = $random(seed);
      write_reg(5'd3, val_a);
      write_reg(5'd4, val_b);
      present(rtype(5'd3, 5'd4, 5'd5, 5'd0, FN_ADDU), 32'h0000_0040);
      step();
      check_eq("addu a", val_a, o_a);
      check_eq("addu b", val_b, o_b);
      check_eq("addu ex", ex_frame(ALU_ADD, 1'b0, 1'b0, 1'b0), 32'(o_ex_ctrl));
      check_eq("addu wb", wb_frame(5'd5, 1'b1, 1'b1, 1'b0), 32'(o_wb_ctrl));
      check_eq("addu pc", 32'h0000_0040, o_pc);
      present(rtype(5'd3, 5'd4, 5'd0, 5'd0, FN_SUBU), 32'h0000_0044);
      step();
      check_eq("subu ex", ex_frame(ALU_SUB, 1'b0, 1'b0, 1'b0), 32'(o_ex_ctrl));
      // r0 as destination drops the write
      check_eq("subu wb", wb_frame(5'd0, 1'b0, 1'b1, 1'b0), 32'(o_wb_ctrl));
   endtask

   task automatic itype_frames();
      present(itype(OP_LHU, 5'd3, 5'd6, 16'h8004), 32'h0000_0048);
      step();
      check_eq("lhu ex", ex_frame(ALU_ADD, 1'b1, 1'b0, 1'b0), 32'(o_ex_ctrl));
      check_eq("lhu mem", mem_frame(1'b1, 1'b0, 1'b1, 2'd1), 32'(o_mem_ctrl));
      check_eq("lhu wb", wb_frame(5'd6, 1'b1, 1'b0, 1'b0), 32'(o_wb_ctrl));
      check_eq("lhu imm", 32'h0000_8004, 32'(o_imm));
      present(itype(OP_SW, 5'd3, 5'd4, 16'h0010), 32'h0000_004c);
      step();
      check_eq("sw ex", ex_frame(ALU_ADD, 1'b1, 1'b0, 1'b0), 32'(o_ex_ctrl));
      check_eq("sw mem", mem_frame(1'b0, 1'b1, 1'b0, 2'd2), 32'(o_mem_ctrl));
      check_eq("sw wb", wb_frame(5'd4, 1'b0, 1'b0, 1'b0), 32'(o_wb_ctrl));
      present(itype(OP_ORI, 5'd3, 5'd7, 16'hf0f0), 32'h0000_0050);
      step();
      check_eq("ori ex", ex_frame(ALU_OR, 1'b1, 1'b1, 1'b0), 32'(o_ex_ctrl));
      check_eq("ori mem", 32'h0, 32'(o_mem_ctrl));
      check_eq("ori wb", wb_frame(5'd7, 1'b1, 1'b1, 1'b0), 32'(o_wb_ctrl));
      check_eq("ori imm", 32'h0000_f0f0, 32'(o_imm));
      present(itype(OP_SLTI, 5'd3, 5'd8, 16'hffff), 32'h0000_0054);
      step();
      check_eq("slti ex", ex_frame(ALU_SLT, 1'b1, 1'b0, 1'b0), 32'(o_ex_ctrl));
      check_eq("slti wb", wb_frame(5'd8, 1'b1, 1'b1, 1'b0), 32'(o_wb_ctrl));
      present(rtype(5'd0, 5'd4, 5'd9, 5'd13, FN_SRA), 32'h0000_0058);
      step();
      check_eq("sra ex", ex_frame(ALU_SRA, 1'b0, 1'b0, 1'b1), 32'(o_ex_ctrl));
      check_eq("sra wb", wb_frame(5'd9, 1'b1, 1'b1, 1'b0), 32'(o_wb_ctrl));
      check_eq("sra shamt", 32'd13, 32'(o_shamt));
      check_eq("sra b", val_b, o_b);
   endtask

   task automatic run_branch(string name, opcode_t op, reg_addr_t rt, logic [31:0] taken);
      present(itype(op, 5'd3, rt, 16'h0008), 32'h0000_0060);
      check_eq(name, 32'h1, 32'(o_branch));
      check_eq(name, taken, 32'(o_branch_result));
      step();
      check_eq(name, taken, 32'(o_nop));
   endtask

   task automatic branch_outcomes();
      run_branch("beq equal", OP_BEQ, 5'd3, 32'h1);
      run_branch("beq unequal", OP_BEQ, 5'd4, 32'(val_a == val_b));
      run_branch("bne equal", OP_BNE, 5'd3, 32'h0);
      run_branch("bne unequal", OP_BNE, 5'd4, 32'(val_a != val_b));
   endtask

   task automatic jump_requests();
      present(jtype(OP_J, 26'h123_4567), 32'h0000_0070);
      check_eq("j inm", 32'h1, 32'(o_jump_inm));
      check_eq("j target", 32'h0123_4567, 32'(o_jump_inm_addr));
      check_eq("j rs", 32'h0, 32'(o_jump_rs));
      step();
      check_eq("j nop", 32'h1, 32'(o_nop));
      present(jtype(OP_JAL, 26'h000_0abc), 32'h0000_0074);
      step();
      check_eq("jal wb", wb_frame(5'd31, 1'b1, 1'b0, 1'b1), 32'(o_wb_ctrl));
      check_eq("jal nop", 32'h1, 32'(o_nop));
      present(rtype(5'd4, 5'd0, 5'd0, 5'd0, FN_JR), 32'h0000_0078);
      check_eq("jr rs", 32'h1, 32'(o_jump_rs));
      check_eq("jr addr", val_b, o_jump_rs_addr);
      step();
      check_eq("jr nop", 32'h1, 32'(o_nop));
      present(rtype(5'd3, 5'd0, 5'd31, 5'd0, FN_JALR), 32'h0000_007c);
      check_eq("jalr rs", 32'h1, 32'(o_jump_rs));
      check_eq("jalr addr", val_a, o_jump_rs_addr);
      step();
      check_eq("jalr wb", wb_frame(5'd31, 1'b1, 1'b1, 1'b1), 32'(o_wb_ctrl));
      check_eq("jalr nop", 32'h1, 32'(o_nop));
   endtask

   task automatic stall_hold();
      present(itype(OP_BEQ, 5'd3, 5'd3, 16'h0008), 32'h0000_0080);
      step();
      save_outputs();
      // Write attempts while the stage is frozen
      i_regfile_we   = 1'b1;
      i_regfile_addr = 5'd10;
      i_regfile_data = 32'hcafe_f00d;
      // Held instructions differ from the saved frame in their fields and pc
      i_valid        = 1'b0;
      i_instruction  = itype(OP_LHU, 5'd4, 5'd7, 16'h1111);
      i_pc           = 32'h0000_0084;
      repeat (2) begin
         #1;
         check_eq("invalid advance", 32'h0, 32'(o_advance));
         step();
         check_held("invalid hold");
      end
      i_valid       = 1'b1;
      i_instruction = jtype(OP_HLT, {5'd4, 5'd7, 16'h1111});
      i_pc          = 32'h0000_0088;
      #1;
      check_eq("hlt advance", 32'h0, 32'(o_advance));
      step();
      check_held("hlt hold");
      i_regfile_we = 1'b0;
      present(rtype(5'd10, 5'd0, 5'd11, 5'd0, FN_ADDU), 32'h0000_0090);
      step();
      check_eq("held write", 32'h0, o_a);
   endtask

   initial begin
      seed           = 32'h28225ff3;
      i_rst          = 1'b1;
      i_valid        = 1'b0;
      i_instruction  = '0;
      i_pc           = '0;
      i_regfile_we   = 1'b0;
      i_regfile_addr = '0;
      i_regfile_data = '0;
      repeat (16) @(posedge i_clk);
      #1;
      i_rst = 1'b0;
      reset_values();
      rtype_ops();
      itype_frames();
      branch_outcomes();
      jump_requests();
      stall_hold();
      $display("Simulation completed successfully");
      $finish;
   end

endmodule

/* vlog.f */
source/id_pkg.sv
source/control_decoder.sv
source/register_file.sv
source/branch_resolver.sv
source/id_ex_register.sv
source/instruction_decode.sv
test/tb_instruction_decode.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -rf obj_dir
{ verilator --binary --timing --assert --timescale 1ns/100ps \
     --top-module tb_instruction_decode -f vlog.f \
  && ./obj_dir/Vtb_instruction_decode; } > "$LOG" 2>&1 \
  || echo "Simulation failed" >> "$LOG"
cat "$LOG"
grep -q "Simulation failed" "$LOG" && { echo "FAIL"; exit 1; }
grep -q "Simulation completed successfully" "$LOG" && echo "PASS" || { echo "FAIL"; exit 1; }
